//--- design/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// Cache geometry.
	localparam int NUM_WAYS    = 4;
	localparam int NUM_SETS    = 16;
	localparam int OFFSET_BITS = 4;
	localparam int INDEX_BITS  = 4;

	// Backing memory depth in lines.
	localparam int MEM_LINES   = 64;

	typedef logic [63:0]                            fetch_addr_t;
	typedef logic [31:0]                            inst_t;
	typedef logic [127:0]                           line_t;
	typedef logic [INDEX_BITS-1:0]                  set_idx_t;
	// Address bits 63 to 8.
	typedef logic [63-OFFSET_BITS-INDEX_BITS:0]     tag_t;
	typedef logic [NUM_WAYS-1:0]                    way_mask_t;

	typedef struct packed {
		logic  ready;
		inst_t inst;
	} fetch_resp_t;

	typedef enum logic {
		HOLD_IDLE,
		HOLD_STALLED
	} hold_state_e;

endpackage

`default_nettype wire

//--- design/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array import icache_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  fetch_addr_t addr,
	input  logic        fill,
	input  way_mask_t   fill_way,
	output way_mask_t   hit_way
);

	logic [NUM_SETS-1:0] valid_bits [NUM_WAYS];
	tag_t                tags       [NUM_WAYS][NUM_SETS];

	set_idx_t index;
	tag_t     req_tag;

	assign index   = addr[OFFSET_BITS +: INDEX_BITS];
	assign req_tag = addr[$bits(fetch_addr_t)-1 : OFFSET_BITS+INDEX_BITS];

	// Parallel compare across all ways.
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			hit_way[w] = valid_bits[w][index] && (tags[w][index] == req_tag);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				valid_bits[w] <= '0;
			end
		end else if (fill) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill_way[w]) begin
					valid_bits[w][index] <= 1'b1;
				end
			end
		end
	end

	// Tag storage only.
	always_ff @(posedge clk) begin
		if (fill) begin
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (fill_way[w]) begin
					tags[w][index] <= req_tag;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/icache_data_sram.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_sram import icache_pkg::*; (
	input  logic     clk,
	input  logic     cen,
	input  logic     wen,
	input  set_idx_t addr,
	input  line_t    din,
	output line_t    dout
);

	line_t mem [NUM_SETS];

	// Active-low enables as on the hard macro.
	always_ff @(posedge clk) begin
		if (!cen) begin
			if (!wen) begin
				mem[addr] <= din;
				// Write-through to the output port.
				dout      <= din;
			end else begin
				dout <= mem[addr];
			end
		end
	end

endmodule

`default_nettype wire

//--- design/inst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module inst_mem import icache_pkg::*; (
	input  fetch_addr_t addr,
	output line_t       line
);

	localparam int LINE_SEL_BITS = $clog2(MEM_LINES);

	line_t rom [MEM_LINES];

	logic [LINE_SEL_BITS-1:0] line_sel;

	initial begin
		$readmemh("inst_lines.hex", rom);
	end

	// Bits above 9 alias back onto the same lines.
	assign line_sel = addr[OFFSET_BITS +: LINE_SEL_BITS];
	assign line     = rom[line_sel];

endmodule

`default_nettype wire

//--- design/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache import icache_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  fetch_addr_t addr,
	input  logic        valid,
	input  logic        flush,
	input  logic        advance,
	output fetch_addr_t line_addr,
	input  line_t       line,
	output fetch_resp_t resp
);

	logic      accept;
	logic      miss;
	way_mask_t hit_way;
	way_mask_t victim;
	set_idx_t  index;

	logic [NUM_WAYS-1:0] cen;
	logic                wen;
	line_t               dout [NUM_WAYS];

	// Response stage.
	logic      ready_q;
	way_mask_t hit_q;
	line_t     line_q;
	logic [1:0] word_q;

	line_t sel_line;
	inst_t live_inst;

	// Stall capture.
	hold_state_e hold_state;
	inst_t       held_inst;

	assign accept    = valid && advance;
	assign miss      = accept && (hit_way == '0);
	assign index     = addr[OFFSET_BITS +: INDEX_BITS];
	assign line_addr = addr;

	icache_tag_array u_tags (
		.clk      (clk),
		.rst      (rst),
		.addr     (addr),
		.fill     (miss),
		.fill_way (victim),
		.hit_way  (hit_way)
	);

	// One-hot round-robin victim pointer.
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= way_mask_t'(1);
		end else if (advance && !flush) begin
			victim <= {victim[NUM_WAYS-2:0], victim[NUM_WAYS-1]};
		end
	end

	// Hit way reads, victim way takes the fill.
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			cen[w] = !(accept && (hit_way[w] || (miss && victim[w])));
		end
	end

	assign wen = !miss;

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		icache_data_sram u_sram (
			.clk  (clk),
			.cen  (cen[w]),
			.wen  (wen),
			.addr (index),
			.din  (line),
			.dout (dout[w])
		);
	end

	// Frozen while advance is low.
	always_ff @(posedge clk) begin
		if (rst) begin
			ready_q <= 1'b0;
			hit_q   <= '0;
			line_q  <= '0;
			word_q  <= '0;
		end else if (advance) begin
			ready_q <= valid && !flush;
			hit_q   <= (valid && !flush) ? hit_way : '0;
			line_q  <= line;
			word_q  <= addr[3:2];
		end
	end

	// Empty mask means the line was bypassed from memory.
	always_comb begin
		sel_line = line_q;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (hit_q[w]) begin
				sel_line = dout[w];
			end
		end
	end

	assign live_inst = sel_line[{word_q, 5'b0} +: $bits(inst_t)];

	always_ff @(posedge clk) begin
		if (rst) begin
			hold_state <= HOLD_IDLE;
		end else begin
			case (hold_state)
				HOLD_IDLE: begin
					if (!advance) begin
						hold_state <= HOLD_STALLED;
					end
				end
				HOLD_STALLED: begin
					if (advance) begin
						hold_state <= HOLD_IDLE;
					end
				end
				default: hold_state <= HOLD_IDLE;
			endcase
		end
	end

	// Grab the word on the first stalled cycle.
	always_ff @(posedge clk) begin
		if (hold_state == HOLD_IDLE && !advance) begin
			held_inst <= live_inst;
		end
	end

	always_comb begin
		resp.ready = ready_q;
		resp.inst  = (hold_state == HOLD_STALLED) ? held_inst : live_inst;
	end

endmodule

`default_nettype wire

//--- design/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top import icache_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  fetch_addr_t addr,
	input  logic        valid,
	input  logic        flush,
	input  logic        advance,
	output fetch_resp_t resp
);

	fetch_addr_t line_addr;
	line_t       line;

	icache u_icache (
		.clk       (clk),
		.rst       (rst),
		.addr      (addr),
		.valid     (valid),
		.flush     (flush),
		.advance   (advance),
		.line_addr (line_addr),
		.line      (line),
		.resp      (resp)
	);

	// Single-cycle line fetch on a miss.
	inst_mem u_mem (
		.addr (line_addr),
		.line (line)
	);

endmodule

`default_nettype wire

//--- tests/icache_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module icache_assertions import icache_pkg::*; (
	input logic        clk,
	input logic        rst,
	input logic        advance,
	input way_mask_t   hit_way,
	input fetch_resp_t resp,
	input hold_state_e hold_state
);

	int fail_count = 0;

	ready_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !resp.ready)
		else begin
			$error("resp.ready is high in the first cycle after reset");
			fail_count++;
		end

	// At most one way may match.
	hit_way_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_way))
		else begin
			$error("hit_way has more than one bit set: %h", hit_way);
			fail_count++;
		end

	// Stalled state means advance was already low the cycle before.
	stall_keeps_resp: assert property (@(posedge clk) disable iff (rst)
		!advance && hold_state == HOLD_STALLED |-> $stable(resp))
		else begin
			$error("resp changed while advance stayed low");
			fail_count++;
		end

endmodule

bind icache icache_assertions u_assert (
	.clk        (clk),
	.rst        (rst),
	.advance    (advance),
	.hit_way    (hit_way),
	.resp       (resp),
	.hold_state (hold_state)
);

`default_nettype wire

//--- tests/fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_checker import icache_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        valid,
	input  logic        flush,
	input  logic        advance,
	input  inst_t       ref_inst,
	input  fetch_resp_t resp,
	output int          checks,
	output int          errors
);

	typedef struct packed {
		logic  check_inst;
		logic  ready;
		inst_t inst;
	} expect_t;

	expect_t held;
	expect_t pending [$];

	initial begin
		checks = 0;
		errors = 0;
		held   = '0;
	end

	// Predict what the response stage holds after this edge.
	always @(posedge clk) begin
		if (rst) begin
			held.check_inst = 1'b1;
			held.ready      = 1'b0;
			held.inst       = '0;
		end else if (advance) begin
			held.check_inst = valid && !flush;
			held.ready      = valid && !flush;
			held.inst       = ref_inst;
		end
		pending.push_back(held);
	end

	// Outputs are settled by the falling edge.
	always @(negedge clk) begin : compare
		expect_t exp;
		if (pending.size() > 0) begin
			exp = pending.pop_front();
			checks++;
			if (resp.ready !== exp.ready) begin
				errors++;
				$display("[FAIL] resp.ready: got %h, expected %h at %0t",
					resp.ready, exp.ready, $time);
			end else if (exp.check_inst && resp.inst !== exp.inst) begin
				errors++;
				$display("[FAIL] resp.inst: got %h, expected %h at %0t",
					resp.inst, exp.inst, $time);
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch import icache_pkg::*; ();

	logic        clk;
	logic        rst;
	fetch_addr_t addr;
	logic        valid;
	logic        flush;
	logic        advance;
	inst_t       ref_inst;
	fetch_resp_t resp;
	int          checks;
	int          errors;

	line_t       ref_lines [MEM_LINES];
	fetch_addr_t pool [8];
	fetch_addr_t same_set [5];
	int unsigned seed;
	int          stall_len;
	int          mark_checks;
	int          mark_errors;

	fetch_top dut (
		.clk     (clk),
		.rst     (rst),
		.addr    (addr),
		.valid   (valid),
		.flush   (flush),
		.advance (advance),
		.resp    (resp)
	);

	fetch_checker u_checker (
		.clk      (clk),
		.rst      (rst),
		.valid    (valid),
		.flush    (flush),
		.advance  (advance),
		.ref_inst (ref_inst),
		.resp     (resp),
		.checks   (checks),
		.errors   (errors)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Word at bits 3:2 of the line at bits 9:4.
	function automatic inst_t expected_inst(input fetch_addr_t a);
		line_t l;
		l = ref_lines[a[9:4]];
		return l[a[3:2] * 32 +: 32];
	endfunction

	function automatic fetch_addr_t pick_addr();
		fetch_addr_t a;
		a = pool[$urandom % 8];
		a[3:2] = 2'($urandom % 4);
		return a;
	endfunction

	function automatic int error_total();
		return errors + dut.u_icache.u_assert.fail_count;
	endfunction

	task automatic drive_cycle(input fetch_addr_t a, input logic v, input logic f,
			input logic adv);
		addr     <= a;
		valid    <= v;
		flush    <= f;
		advance  <= adv;
		ref_inst <= expected_inst(a);
		@(posedge clk);
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		valid   <= 1'b0;
		flush   <= 1'b0;
		advance <= 1'b1;
		@(negedge clk);
		while (resp.ready && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (resp.ready) begin
			$display("timeout: the response stream never went idle");
			$display("test failed");
			$finish;
		end else begin
			@(posedge clk);
		end
	endtask

	task automatic report_test(input string name);
		$display("%-12s %0d checks, %0d errors", name, checks - mark_checks,
			error_total() - mark_errors);
		mark_checks = checks;
		mark_errors = error_total();
	endtask

	initial begin
		$readmemh("inst_lines.hex", ref_lines);
		seed = 32'h94c1;
		void'($urandom(seed));
		pool = '{64'h000, 64'h0a4, 64'h1a0, 64'h2a8, 64'h3ac,
			64'hffff_0000_0000_00a0, 64'h3f0, 64'h124};
		same_set = '{64'h050, 64'h150, 64'h250, 64'h350, 64'h1000_0000_0000_0050};
		rst         = 1'b1;
		addr        = '0;
		valid       = 1'b0;
		flush       = 1'b0;
		advance     = 1'b1;
		ref_inst    = '0;
		mark_checks = 0;
		mark_errors = 0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < 16; i++) begin
			drive_cycle(fetch_addr_t'(i * 16 + (i % 4) * 4), 1'b1, 1'b0, 1'b1);
		end
		wait_idle();
		report_test("cold_miss");

		for (int i = 0; i < 16; i++) begin
			for (int w = 0; w < 4; w++) begin
				drive_cycle(fetch_addr_t'(i * 16 + w * 4), 1'b1, 1'b0, 1'b1);
			end
		end
		wait_idle();
		report_test("hit");

		// Five lines into four ways keeps evicting.
		for (int r = 0; r < 4; r++) begin
			for (int i = 0; i < 5; i++) begin
				drive_cycle(same_set[i] | fetch_addr_t'(((r + i) % 4) * 4),
					1'b1, 1'b0, 1'b1);
			end
		end
		wait_idle();
		report_test("replace");

		for (int i = 0; i < 24; i++) begin
			if (i == 8 || i == 16) begin
				stall_len = 2 + $urandom % 6;
				repeat (stall_len) begin
					drive_cycle(pick_addr(), 1'($urandom % 2), 1'($urandom % 2), 1'b0);
				end
			end
			drive_cycle(pick_addr(), 1'b1, 1'b0, 1'b1);
		end
		wait_idle();
		report_test("stall");

		for (int i = 0; i < 8; i++) begin
			drive_cycle(pick_addr(), 1'b1, 1'b1, 1'b1);
			drive_cycle(pick_addr(), 1'b0, 1'b0, 1'b1);
			drive_cycle(pick_addr(), 1'b1, 1'b0, 1'b1);
		end
		wait_idle();
		report_test("flush");

		for (int i = 0; i < 300; i++) begin
			drive_cycle(pick_addr(), 1'($urandom % 4 != 0), 1'($urandom % 8 == 0),
				1'($urandom % 4 != 0));
		end
		wait_idle();
		report_test("random_mix");

		$display("%0d checks, %0d errors", checks, error_total());
		if (error_total() == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
design/icache_pkg.sv
design/icache_tag_array.sv
design/icache_data_sram.sv
design/inst_mem.sv
design/icache.sv
design/fetch_top.sv
tests/icache_assertions.sv
tests/fetch_checker.sv
tests/tb_fetch.sv

//--- inst_lines.hex
// One 128-bit line per row, indexed by address bits 9 to 4.
// Columns run from word 3 on the left down to word 0 on the right.
003000b3002000330010009300000013
013010b3012010330110109301001013
023020b3022020330210209302002013
033030b3032030330310309303003013
043040b3042040330410409304004013
053050b3052050330510509305005013
063060b3062060330610609306006013
073070b3072070330710709307007013
083080b3082080330810809308008013
093090b3092090330910909309009013
0a30a0b30a20a0330a10a0930a00a013
0b30b0b30b20b0330b10b0930b00b013
0c30c0b30c20c0330c10c0930c00c013
0d30d0b30d20d0330d10d0930d00d013
0e30e0b30e20e0330e10e0930e00e013
0f30f0b30f20f0330f10f0930f00f013
103100b3102100331010109310010013
113110b3112110331110109311011013
123120b3122120331210209312012013
133130b3132130331310309313013013
143140b3142140331410409314014013
153150b3152150331510509315015013
163160b3162160331610609316016013
173170b3172170331710709317017013
183180b3182180331810809318018013
193190b3192190331910909319019013
1a31a0b31a21a0331a11a0931a01a013
1b31b0b31b21b0331b11b0931b01b013
1c31c0b31c21c0331c11c0931c01c013
1d31d0b31d21d0331d11d0931d01d013
1e31e0b31e21e0331e11e0931e01e013
1f31f0b31f21f0331f11f0931f01f013
203200b3202200332010209320020013
213210b3212210332110209321021013
223220b3222220332210209322022013
233230b3232230332310309323023013
243240b3242240332410409324024013
253250b3252250332510509325025013
263260b3262260332610609326026013
273270b3272270332710709327027013
283280b3282280332810809328028013
293290b3292290332910909329029013
2a32a0b32a22a0332a12a0932a02a013
2b32b0b32b22b0332b12b0932b02b013
2c32c0b32c22c0332c12c0932c02c013
2d32d0b32d22d0332d12d0932d02d013
2e32e0b32e22e0332e12e0932e02e013
2f32f0b32f22f0332f12f0932f02f013
303300b3302300333010309330030013
313310b3312310333110309331031013
323320b3322320333210309332032013
333330b3332330333310309333033013
343340b3342340333410409334034013
353350b3352350333510509335035013
363360b3362360333610609336036013
373370b3372370333710709337037013
383380b3382380333810809338038013
393390b3392390333910909339039013
3a33a0b33a23a0333a13a0933a03a013
3b33b0b33b23b0333b13b0933b03b013
3c33c0b33c23c0333c13c0933c03c013
3d33d0b33d23d0333d13d0933d03d013
3e33e0b33e23e0333e13e0933e03e013
3f33f0b33f23f0333f13f0933f03f013
